/* list.f */
+incdir+testbench
design/wr_stats_pkg.sv
design/wr_event_decode.sv
design/stat_accum.sv
design/stats_regfile.sv
design/axi_wr_stats.sv
testbench/axi_wr_stats_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wall -Wno-fatal \
  --top-module axi_wr_stats_tb \
  -f list.f \
  -o axi_wr_stats_sim

./obj_dir/axi_wr_stats_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation finished without failures"

/* testbench/axil_tasks.svh */
`ifndef AXIL_TASKS_SVH
`define AXIL_TASKS_SVH

// ----------------------------------------
// typed compares
// ----------------------------------------
task automatic check_stat(input string name, input wr_stats_pkg::stat_t got,
                          input wr_stats_pkg::stat_t exp);
  if (got !== exp) begin
    $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    errors++;
  end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
  if (got !== exp) begin
    $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    errors++;
  end
endtask

// ----------------------------------------
// register port
// ----------------------------------------
// q returns the model cycle of the address handshake
task automatic reg_read(input logic [7:0] addr, output wr_stats_pkg::stat_t data,
                        output logic [1:0] resp, output int q);
  int hold;
  wr_stats_pkg::stat_t first;
  hold = $urandom % 4;
  @(negedge clk);
  s_axil_araddr  = addr;
  s_axil_arvalid = 1'b1;
  while (!s_axil_arready) @(negedge clk);
  q = cyc + 1;
  @(negedge clk);
  s_axil_arvalid = 1'b0;
  while (!s_axil_rvalid) @(negedge clk);
  first = s_axil_rdata;
  // back-pressure, data must hold
  repeat (hold) begin
    @(negedge clk);
    if (s_axil_rdata !== first) begin
      $display("error: s_axil_rdata got 0x%h expected 0x%h", s_axil_rdata, first);
      errors++;
    end
  end
  data = first;
  resp = s_axil_rresp;
  s_axil_rready = 1'b1;
  @(negedge clk);
  s_axil_rready = 1'b0;
endtask

task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                         output logic [1:0] resp, output int w);
  @(negedge clk);
  s_axil_awaddr  = addr;
  s_axil_wdata   = data;
  s_axil_wstrb   = 4'hf;
  s_axil_awvalid = 1'b1;
  s_axil_wvalid  = 1'b1;
  while (!(s_axil_awready && s_axil_wready)) @(negedge clk);
  w = cyc + 1;
  @(negedge clk);
  s_axil_awvalid = 1'b0;
  s_axil_wvalid  = 1'b0;
  while (!s_axil_bvalid) @(negedge clk);
  resp = s_axil_bresp;
  s_axil_bready = 1'b1;
  @(negedge clk);
  s_axil_bready = 1'b0;
endtask

`endif

/* testbench/axi_wr_stats_tb.sv */
module axi_wr_stats_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct {
    logic [7:0] len;
    logic [2:0] size;
    logic [3:0] strb;
    int         wr_wait;
    int         b_wait;
    logic [1:0] resp;
    int         burst_bytes;
    int         beat_bytes;
  } entry_t;

  localparam int num_entries  = 8;
  localparam int burst_cycles = 64;
  localparam int log_depth    = 16384;

  // len, size, strobe, wready wait, bready wait, bresp, burst bytes, beat bytes
  entry_t tbl [num_entries] = '{
    '{8'd0, 3'd2, 4'hf, 0, 0, 2'b00,  4, 4},
    '{8'd3, 3'd2, 4'hf, 1, 0, 2'b00, 16, 4},
    '{8'd1, 3'd1, 4'h3, 0, 2, 2'b10,  4, 2},
    '{8'd7, 3'd2, 4'hf, 0, 1, 2'b00, 32, 4},
    '{8'd2, 3'd0, 4'h1, 2, 0, 2'b11,  3, 1},
    '{8'd4, 3'd2, 4'h5, 1, 3, 2'b00, 20, 2},
    '{8'd5, 3'd2, 4'h7, 0, 0, 2'b10, 24, 3},
    '{8'd1, 3'd2, 4'he, 3, 1, 2'b00,  8, 3}
  };

  logic clk = 1'b0;
  logic rst_n;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic [7:0] awlen;
  logic [2:0] awsize;
  logic [3:0] wstrb;
  logic [1:0] bresp;
  logic [7:0] s_axil_awaddr, s_axil_araddr;
  logic [31:0] s_axil_wdata, s_axil_rdata;
  logic [3:0] s_axil_wstrb;
  logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
  logic s_axil_rvalid, s_axil_rready;
  logic [1:0] s_axil_bresp, s_axil_rresp;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cyc = 0;
  int base_cyc = 0;

  // reference model state and per-cycle log
  int m_aw_open = 0;
  int m_w_open = 0;
  bit m_in_prog = 1'b0;
  wr_stats_pkg::stat_vec_t m_amt;
  logic [wr_stats_pkg::num_stats-1:0] m_hit;
  wr_stats_pkg::stat_vec_t amt_log [log_depth];
  logic [wr_stats_pkg::num_stats-1:0] hit_log [log_depth];

  always #4 clk = ~clk;

  axi_wr_stats i_dut (.*);

  `include "axil_tasks.svh"

  // ----------------------------------------
  // reference model, samples the bus at each rising edge
  // ----------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      cyc = cyc + 1;
      m_hit = '0;
      for (int k = 0; k < wr_stats_pkg::num_stats; k++) m_amt[k] = 1;
      m_amt[wr_stats_pkg::aw_bytes] = (wr_stats_pkg::stat_t'(awlen) + 1) << awsize;
      m_amt[wr_stats_pkg::w_bytes]  = $countones(wstrb);
      m_hit[wr_stats_pkg::aw_bursts] = awvalid && awready;
      m_hit[wr_stats_pkg::aw_bytes]  = awvalid && awready;
      m_hit[wr_stats_pkg::w_beats]   = wvalid && wready;
      m_hit[wr_stats_pkg::w_bytes]   = wvalid && wready;
      m_hit[wr_stats_pkg::b_errors]  = bvalid && bready && bresp != 2'b00;
      if (m_aw_open == 0 && m_w_open == 0 && !m_in_prog && !awvalid && !wvalid)
        m_hit[wr_stats_pkg::idle] = 1'b1;
      else if (wvalid && !wready)
        m_hit[wr_stats_pkg::stall] = 1'b1;
      else if (bvalid && !bready)
        m_hit[wr_stats_pkg::b_stall] = 1'b1;
      else if (m_w_open != 0 && !wvalid && !bvalid)
        m_hit[wr_stats_pkg::b_lag] = 1'b1;
      else if (m_in_prog && !wvalid)
        m_hit[wr_stats_pkg::slow_data] = 1'b1;
      else if (awvalid && !awready)
        m_hit[wr_stats_pkg::addr_lag] = 1'b1;
      else if (m_aw_open != 0 && !m_in_prog && !wvalid)
        m_hit[wr_stats_pkg::data_lag] = 1'b1;
      if (cyc < log_depth) begin
        hit_log[cyc] = m_hit;
        amt_log[cyc] = m_amt;
      end
      m_aw_open = m_aw_open + int'(awvalid && awready) - int'(bvalid && bready);
      m_w_open  = m_w_open + int'(wvalid && wready && wlast) - int'(bvalid && bready);
      if (wvalid) m_in_prog = !(wready && wlast);
    end
  end

  // registers at handshake cycle q hold bus cycles up to q-2
  function automatic wr_stats_pkg::stat_t model_value(int k, bit want_max, int q);
    wr_stats_pkg::stat_t acc;
    acc = '0;
    for (int c = base_cyc + 1; c <= q - 2 && c < log_depth; c++) begin
      if (hit_log[c][k]) begin
        if (want_max) acc = (amt_log[c][k] > acc) ? amt_log[c][k] : acc;
        else acc = acc + amt_log[c][k];
      end
    end
    return acc;
  endfunction

  task automatic check_all_regs();
    wr_stats_pkg::stat_t data;
    logic [1:0] resp;
    int q;
    for (int k = 0; k < wr_stats_pkg::num_stats; k++) begin
      for (int m = 0; m < 2; m++) begin
        reg_read(8'(k * 8 + m * 4), data, resp, q);
        check_stat($sformatf("%s %0d", m ? "max" : "sum", k), data, model_value(k, m, q));
        check_resp("s_axil_rresp", resp, wr_stats_pkg::resp_okay);
      end
    end
  endtask

  task automatic check_reg(input int addr, input wr_stats_pkg::stat_t exp);
    wr_stats_pkg::stat_t data;
    logic [1:0] resp;
    int q;
    reg_read(8'(addr), data, resp, q);
    check_stat($sformatf("register 0x%02h", addr), data, exp);
    check_resp("s_axil_rresp", resp, wr_stats_pkg::resp_okay);
  endtask

  // one complete burst, the testbench acting as both master and slave
  task automatic run_burst(input entry_t e);
    int aw_wait;
    int lag;
    aw_wait = $urandom % 3;
    lag = $urandom % 2;
    awlen  = e.len;
    awsize = e.size;
    wstrb  = e.strb;
    bresp  = e.resp;
    for (int i = 0; i <= aw_wait; i++) begin
      @(negedge clk);
      awvalid = 1'b1;
      awready = (i == aw_wait);
    end
    @(negedge clk);
    awvalid = 1'b0;
    awready = 1'b0;
    repeat (lag) @(negedge clk);
    for (int b = 0; b <= e.len; b++) begin
      for (int i = 0; i <= e.wr_wait; i++) begin
        @(negedge clk);
        wvalid = 1'b1;
        wready = (i == e.wr_wait);
        wlast  = (b == e.len);
      end
      // occasional gap inside the burst
      if (b < e.len && ($urandom % 2) == 1) begin
        @(negedge clk);
        wvalid = 1'b0;
        wready = 1'b0;
      end
    end
    @(negedge clk);
    wvalid = 1'b0;
    wready = 1'b0;
    wlast  = 1'b0;
    for (int i = 0; i <= e.b_wait; i++) begin
      @(negedge clk);
      bvalid = 1'b1;
      bready = (i == e.b_wait);
    end
    @(negedge clk);
    bvalid = 1'b0;
    bready = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - errs_before);
    end
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    #((num_entries * 2 * burst_cycles + 8 * 24 * 12 + 500) * 8);
    $display("timeout: simulation did not reach the end of the tests");
    $display("Checks failed");
    $finish;
  end

  initial begin
    int e0;
    int w;
    logic [1:0] resp;
    wr_stats_pkg::stat_t data;
    wr_stats_pkg::stat_t tot_bytes, tot_wbytes, tot_beats, n_err;
    int q;
    void'($urandom(2));
    rst_n = 1'b0;
    {awvalid, awready, wvalid, wready, wlast, bvalid, bready} = '0;
    awlen = '0;
    awsize = '0;
    wstrb = '0;
    bresp = '0;
    {s_axil_awvalid, s_axil_wvalid, s_axil_bready, s_axil_arvalid, s_axil_rready} = '0;
    s_axil_awaddr = '0;
    s_axil_araddr = '0;
    s_axil_wdata = '0;
    s_axil_wstrb = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    e0 = errors;
    check_all_regs();
    end_test("reset values", e0);

    for (int i = 0; i < num_entries; i++) run_burst(tbl[i]);
    tot_bytes = 0;
    tot_wbytes = 0;
    tot_beats = 0;
    n_err = 0;
    for (int i = 0; i < num_entries; i++) begin
      tot_bytes  += tbl[i].burst_bytes;
      tot_beats  += tbl[i].len + 1;
      tot_wbytes += tbl[i].beat_bytes * (tbl[i].len + 1);
      if (tbl[i].resp != 2'b00) n_err++;
    end

    e0 = errors;
    check_reg(8'h00, num_entries);
    check_reg(8'h04, 1);
    check_reg(8'h08, tot_bytes);
    check_reg(8'h0c, 32);
    check_reg(8'h10, tot_beats);
    check_reg(8'h14, 1);
    check_reg(8'h18, tot_wbytes);
    check_reg(8'h1c, 4);
    end_test("byte and beat totals", e0);

    e0 = errors;
    check_reg(8'h20, n_err);
    end_test("response errors", e0);

    e0 = errors;
    check_all_regs();
    end_test("cycle bins", e0);

    e0 = errors;
    reg_write(wr_stats_pkg::clear_addr, 32'h1, resp, w);
    check_resp("s_axil_bresp", resp, wr_stats_pkg::resp_okay);
    base_cyc = w + 1;
    repeat (3) @(negedge clk);
    check_all_regs();
    run_burst(tbl[3]);
    reg_write(8'h10, 32'h1, resp, w);
    check_resp("s_axil_bresp", resp, wr_stats_pkg::resp_slverr);
    repeat (3) @(negedge clk);
    check_all_regs();
    end_test("clear register", e0);

    e0 = errors;
    reg_read(8'h60, data, resp, q);
    check_stat("s_axil_rdata", data, '0);
    check_resp("s_axil_rresp", resp, wr_stats_pkg::resp_slverr);
    reg_read(8'h02, data, resp, q);
    check_stat("s_axil_rdata", data, '0);
    check_resp("s_axil_rresp", resp, wr_stats_pkg::resp_slverr);
    end_test("unmapped reads", e0);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* design/axi_wr_stats.sv */
module axi_wr_stats (
  input  logic                                     clk,
  input  logic                                     rst_n,

  // monitored write bus
  input  logic                                     awvalid,
  input  logic                                     awready,
  input  logic [7:0]                               awlen,
  input  logic [2:0]                               awsize,
  input  logic                                     wvalid,
  input  logic                                     wready,
  input  logic [wr_stats_pkg::strb_width-1:0]      wstrb,
  input  logic                                     wlast,
  input  logic                                     bvalid,
  input  logic                                     bready,
  input  logic [1:0]                               bresp,

  // register port
  input  logic [wr_stats_pkg::axil_addr_width-1:0] s_axil_awaddr,
  input  logic                                     s_axil_awvalid,
  output logic                                     s_axil_awready,
  input  logic [wr_stats_pkg::axil_data_width-1:0] s_axil_wdata,
  input  logic [wr_stats_pkg::axil_strb_width-1:0] s_axil_wstrb,
  input  logic                                     s_axil_wvalid,
  output logic                                     s_axil_wready,
  output logic                                     s_axil_bvalid,
  output logic [1:0]                               s_axil_bresp,
  input  logic                                     s_axil_bready,
  input  logic [wr_stats_pkg::axil_addr_width-1:0] s_axil_araddr,
  input  logic                                     s_axil_arvalid,
  output logic                                     s_axil_arready,
  output logic                                     s_axil_rvalid,
  output logic [wr_stats_pkg::axil_data_width-1:0] s_axil_rdata,
  output logic [1:0]                               s_axil_rresp,
  input  logic                                     s_axil_rready
);

  wr_stats_pkg::stat_vec_t            amount;
  logic [wr_stats_pkg::num_stats-1:0] hit;
  wr_stats_pkg::stat_vec_t            sums;
  wr_stats_pkg::stat_vec_t            maxes;
  logic                               stat_clear;

  wr_event_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .awvalid    (awvalid),
    .awready    (awready),
    .awlen      (awlen),
    .awsize     (awsize),
    .wvalid     (wvalid),
    .wready     (wready),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .amount     (amount),
    .hit        (hit)
  );

  // one accumulator per statistic
  for (genvar i = 0; i < wr_stats_pkg::num_stats; i++) begin : g_accum
    stat_accum u_accum (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (stat_clear),
      .hit    (hit[i]),
      .amount (amount[i]),
      .sum    (sums[i]),
      .max    (maxes[i])
    );
  end

  stats_regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .awaddr     (s_axil_awaddr),
    .awvalid    (s_axil_awvalid),
    .awready    (s_axil_awready),
    .wdata      (s_axil_wdata),
    .wstrb      (s_axil_wstrb),
    .wvalid     (s_axil_wvalid),
    .wready     (s_axil_wready),
    .bvalid     (s_axil_bvalid),
    .bresp      (s_axil_bresp),
    .bready     (s_axil_bready),
    .araddr     (s_axil_araddr),
    .arvalid    (s_axil_arvalid),
    .arready    (s_axil_arready),
    .rvalid     (s_axil_rvalid),
    .rdata      (s_axil_rdata),
    .rresp      (s_axil_rresp),
    .rready     (s_axil_rready),
    .sums       (sums),
    .maxes      (maxes),
    .stat_clear (stat_clear)
  );

endmodule

/* design/stats_regfile.sv */
module stats_regfile (
  input  logic                                     clk,
  input  logic                                     rst_n,

  // write channels for the clear register
  input  logic [wr_stats_pkg::axil_addr_width-1:0] awaddr,
  input  logic                                     awvalid,
  output logic                                     awready,
  input  logic [wr_stats_pkg::axil_data_width-1:0] wdata,
  input  logic [wr_stats_pkg::axil_strb_width-1:0] wstrb,
  input  logic                                     wvalid,
  output logic                                     wready,
  output logic                                     bvalid,
  output logic [1:0]                               bresp,
  input  logic                                     bready,

  // read channels
  input  logic [wr_stats_pkg::axil_addr_width-1:0] araddr,
  input  logic                                     arvalid,
  output logic                                     arready,
  output logic                                     rvalid,
  output logic [wr_stats_pkg::axil_data_width-1:0] rdata,
  output logic [1:0]                               rresp,
  input  logic                                     rready,

  input  wr_stats_pkg::stat_vec_t                  sums,
  input  wr_stats_pkg::stat_vec_t                  maxes,
  output logic                                     stat_clear
);

  logic                                     ar_hs;
  logic                                     wr_hs;
  logic                                     wr_is_clear;
  logic [wr_stats_pkg::axil_addr_width-4:0] rd_idx;
  logic                                     rd_mapped;
  logic [wr_stats_pkg::axil_data_width-1:0] rd_value;

  // ----------------------------------------
  // read side
  // ----------------------------------------
  assign arready = !rvalid;
  assign ar_hs   = arvalid && arready;

  // bits [7:3] pick the statistic and bit 2 picks sum or max
  assign rd_idx    = araddr[wr_stats_pkg::axil_addr_width-1:3];
  assign rd_mapped = (araddr[1:0] == 2'b00) && (rd_idx < wr_stats_pkg::num_stats);

  always_comb begin
    rd_value = '0;
    if (rd_mapped) begin
      rd_value = araddr[2] ? maxes[rd_idx] : sums[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (ar_hs) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // latched at the address handshake and held through back-pressure
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata <= rd_value;
      rresp <= rd_mapped ? wr_stats_pkg::resp_okay : wr_stats_pkg::resp_slverr;
    end
  end

  // ----------------------------------------
  // write side
  // ----------------------------------------
  assign awready = !bvalid;
  assign wready  = !bvalid;
  assign wr_hs   = awvalid && wvalid && !bvalid;

  // the address alone selects the clear register
  assign wr_is_clear = (awaddr == wr_stats_pkg::clear_addr);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid     <= 1'b0;
      stat_clear <= 1'b0;
    end else begin
      stat_clear <= wr_hs && wr_is_clear && (wstrb != '0);
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= wr_is_clear ? wr_stats_pkg::resp_okay : wr_stats_pkg::resp_slverr;
    end
  end

endmodule

/* design/stat_accum.sv */
module stat_accum (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear,
  input  logic                hit,
  input  wr_stats_pkg::stat_t amount,
  output wr_stats_pkg::stat_t sum,
  output wr_stats_pkg::stat_t max
);

  // ----------------------------------------
  // running total
  // ----------------------------------------
  // wraps silently at the top of the range
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      sum <= '0;
    end else if (hit) begin
      sum <= sum + amount;
    end
  end

  // ----------------------------------------
  // running maximum
  // ----------------------------------------
  // for unit counts this ends up as an ever-happened flag,
  // for byte counts it holds the largest single burst or beat
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      max <= '0;
    end else if (hit && amount > max) begin
      max <= amount;
    end
  end

endmodule

/* design/wr_event_decode.sv */
module wr_event_decode (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                stat_clear,

  // monitored write bus, observe only
  input  logic                                awvalid,
  input  logic                                awready,
  input  logic [7:0]                          awlen,
  input  logic [2:0]                          awsize,
  input  logic                                wvalid,
  input  logic                                wready,
  input  logic [wr_stats_pkg::strb_width-1:0] wstrb,
  input  logic                                wlast,
  input  logic                                bvalid,
  input  logic                                bready,
  input  logic [1:0]                          bresp,

  output wr_stats_pkg::stat_vec_t             amount,
  output logic [wr_stats_pkg::num_stats-1:0]  hit
);

  logic                              aw_hs;
  logic                              w_hs;
  logic                              w_last_hs;
  logic                              b_hs;

  logic [7:0]                        aw_open;
  logic [7:0]                        w_open;
  logic                              w_in_progress;

  wr_stats_pkg::stat_t               strb_count;
  wr_stats_pkg::stat_vec_t           amount_d;
  logic [wr_stats_pkg::num_stats-1:0] hit_d;

  assign aw_hs     = awvalid && awready;
  assign w_hs      = wvalid && wready;
  assign w_last_hs = w_hs && wlast;
  assign b_hs      = bvalid && bready;

  // ----------------------------------------
  // outstanding transaction tracking
  // ----------------------------------------
  // aw_open: address accepted, response not yet taken
  // w_open: last data beat accepted, response not yet taken
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      aw_open <= 8'd0;
      w_open  <= 8'd0;
    end else begin
      aw_open <= aw_open + 8'(aw_hs) - 8'(b_hs);
      w_open  <= w_open + 8'(w_last_hs) - 8'(b_hs);
    end
  end

  // a burst counts as begun once its first beat is presented
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_in_progress <= 1'b0;
    end else if (wvalid) begin
      w_in_progress <= !(wready && wlast);
    end
  end

  // bytes enabled on this beat
  always_comb begin
    strb_count = '0;
    for (int i = 0; i < wr_stats_pkg::strb_width; i++) begin
      strb_count = strb_count + wr_stats_pkg::stat_t'(wstrb[i]);
    end
  end

  // ----------------------------------------
  // per-cycle classification
  // ----------------------------------------
  always_comb begin
    // every statistic counts by one except the byte totals
    amount_d = '0;
    for (int i = 0; i < wr_stats_pkg::num_stats; i++) begin
      amount_d[i] = wr_stats_pkg::stat_t'(1);
    end
    amount_d[wr_stats_pkg::aw_bytes] =
      (wr_stats_pkg::stat_t'(awlen) + wr_stats_pkg::stat_t'(1)) << awsize;
    amount_d[wr_stats_pkg::w_bytes] = strb_count;

    hit_d = '0;
    hit_d[wr_stats_pkg::aw_bursts] = aw_hs;
    hit_d[wr_stats_pkg::aw_bytes]  = aw_hs;
    hit_d[wr_stats_pkg::w_beats]   = w_hs;
    hit_d[wr_stats_pkg::w_bytes]   = w_hs;
    hit_d[wr_stats_pkg::b_errors]  = b_hs && (bresp != wr_stats_pkg::resp_okay);

    // exclusive bins, first match wins
    if (aw_open == 8'd0 && w_open == 8'd0 && !w_in_progress && !awvalid && !wvalid) begin
      hit_d[wr_stats_pkg::idle] = 1'b1;
    end else if (wvalid && !wready) begin
      hit_d[wr_stats_pkg::stall] = 1'b1;
    end else if (bvalid && !bready) begin
      hit_d[wr_stats_pkg::b_stall] = 1'b1;
    end else if (w_open != 8'd0 && !wvalid && !bvalid) begin
      hit_d[wr_stats_pkg::b_lag] = 1'b1;
    end else if (w_in_progress && !wvalid) begin
      hit_d[wr_stats_pkg::slow_data] = 1'b1;
    end else if (awvalid && !awready) begin
      hit_d[wr_stats_pkg::addr_lag] = 1'b1;
    end else if (aw_open != 8'd0 && !w_in_progress && !wvalid) begin
      hit_d[wr_stats_pkg::data_lag] = 1'b1;
    end
  end

  // one cycle of latency into the accumulators
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      hit <= '0;
    end else begin
      hit <= hit_d;
    end
  end

  always_ff @(posedge clk) begin
    amount <= amount_d;
  end

endmodule

/* design/wr_stats_pkg.sv */
package wr_stats_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int stat_width      = 32;
  localparam int axi_data_width  = 32;
  localparam int strb_width      = axi_data_width / 8;
  localparam int axil_addr_width = 8;
  localparam int axil_data_width = 32;
  localparam int axil_strb_width = axil_data_width / 8;
  localparam int num_stats       = 12;

  typedef logic [stat_width-1:0] stat_t;
  typedef stat_t [num_stats-1:0] stat_vec_t;

  // statistic index, also the register slot
  // slots 0 to 4 count handshake events and bytes
  // slots 5 to 11 are the exclusive cycle bins, listed in priority order
  typedef enum logic [3:0] {
    aw_bursts = 4'd0,
    aw_bytes  = 4'd1,
    w_beats   = 4'd2,
    w_bytes   = 4'd3,
    b_errors  = 4'd4,
    idle      = 4'd5,
    stall     = 4'd6,
    b_stall   = 4'd7,
    b_lag     = 4'd8,
    slow_data = 4'd9,
    addr_lag  = 4'd10,
    data_lag  = 4'd11
  } stat_id_e;

  // ----------------------------------------
  // register map
  // ----------------------------------------
  // sum of stat i at i*8, max at i*8+4
  localparam logic [axil_addr_width-1:0] clear_addr = 8'hFC;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage
